/* design/video_timing_pkg.sv */
// Raster types shared by the timing generator and the pixel pipeline.
// Every pipeline stage carries a raster_t next to its pixel data so that
// the sync and blank outputs leave the engine aligned with the colour.
// Import with a wildcard in the module header.

package video_timing_pkg;

    // horizontal count runs two clocks per pixel
    typedef logic [10:0] hcount_t;

    typedef logic [9:0] vcount_t;

    typedef struct packed {
        hcount_t hcount;
        vcount_t vcount;
        logic    hsync;    // active low
        logic    vsync;    // active low
        logic    blank_n;
        logic    pix_clk;
    } raster_t;

    // pipeline register value while reset is held or the pipe is filling
    localparam raster_t raster_idle = '{
        hcount:  '0,
        vcount:  '0,
        hsync:   1'b1,
        vsync:   1'b1,
        blank_n: 1'b0,
        pix_clk: 1'b0
    };

endpackage

/* design/sprite_pkg.sv */
// Sprite engine definitions: object records as written over the bus,
// the register decode kinds, the sprite pixel write port and colours.
// object_t lines up with writedata[31:1] of an object write, so the bank
// stores the bus word directly.

package sprite_pkg;

    typedef logic [11:0] coord_t;

    // all sprites are square
    localparam int sprite_dim = 16;
    localparam int sprite_pixels = sprite_dim * sprite_dim;

    typedef logic [7:0] pixel_index_t;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } rgb_t;

    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [5:0] sprite;
        logic       active;
    } object_t;

    typedef enum logic [1:0] {
        reg_background,
        reg_object,
        reg_sprite_pixel,
        reg_none
    } reg_kind_t;

    typedef struct packed {
        logic         strobe;
        logic [13:0]  address;   // sprite * 256 + row * 16 + column
        pixel_index_t index;
    } sprite_write_t;

    localparam rgb_t reset_background = 24'h000080;

endpackage

/* design/raster_timing.sv */
// Raster timer. Counts clocks per line and lines per field and derives the
// sync, blanking and pixel clock for the current count. The raster output
// is combinational from the counters; the pipeline registers it.

`timescale 1ns/10ps

module raster_timing import video_timing_pkg::*; #(
    parameter int h_active = 1280,
    parameter int h_front  = 32,
    parameter int h_sync   = 192,
    parameter int h_back   = 96,
    parameter int v_active = 480,
    parameter int v_front  = 10,
    parameter int v_sync   = 2,
    parameter int v_back   = 33
) (
    input  logic    clk,
    input  logic    reset,
    output raster_t raster
);

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;
    localparam int h_sync_start = h_active + h_front;
    localparam int v_sync_start = v_active + v_front;

    hcount_t hcount;
    vcount_t vcount;
    logic    end_of_line;
    logic    end_of_field;

    assign end_of_line = hcount == hcount_t'(h_total - 1);
    assign end_of_field = vcount == vcount_t'(v_total - 1);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
            vcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
            vcount <= end_of_field ? '0 : vcount + 1'b1;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    always_comb begin
        raster.hcount = hcount;
        raster.vcount = vcount;
        raster.hsync = !(hcount >= hcount_t'(h_sync_start) &&
                         hcount < hcount_t'(h_sync_start + h_sync));
        raster.vsync = !(vcount >= vcount_t'(v_sync_start) &&
                         vcount < vcount_t'(v_sync_start + v_sync));
        raster.blank_n = hcount < hcount_t'(h_active) && vcount < vcount_t'(v_active);
        raster.pix_clk = hcount[0];  // half the system clock
    end

endmodule

/* design/register_bank.sv */
// Bus side of the engine. Decodes chipselect/write cycles into the
// background colour, the object table and sprite pixel writes.
// Address 0 is the background, 1..num_objects the objects, 31 a sprite
// pixel; every other address is ignored. Writes land on the strobe edge.

`timescale 1ns/10ps

module register_bank import sprite_pkg::*; #(
    parameter int num_objects  = 8,
    parameter int sprite_count = 4
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            chipselect,
    input  logic                            write,
    input  logic [4:0]                      address,
    input  logic [31:0]                     writedata,
    output rgb_t                            background,
    output object_t [num_objects-1:0]       objects,
    output sprite_write_t                   sprite_write
);

    reg_kind_t kind;
    logic      bus_write;

    assign bus_write = chipselect && write;

    always_comb begin
        if (address == 5'd0) begin
            kind = reg_background;
        end else if (address == 5'd31) begin
            kind = reg_sprite_pixel;
        end else if (int'(address) <= num_objects) begin
            kind = reg_object;
        end else begin
            kind = reg_none;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            background <= reset_background;
            objects <= '0;  // every object inactive
        end else if (bus_write) begin
            if (kind == reg_background) begin
                background <= writedata[23:0];
            end
            for (int i = 0; i < num_objects; i++) begin
                if (kind == reg_object && address == 5'(i + 1)) begin
                    objects[i] <= writedata[31:1];
                end
            end
        end
    end

    // pixels past the last sprite are dropped
    always_comb begin
        sprite_write.strobe = bus_write && kind == reg_sprite_pixel &&
                              writedata[21:8] < 14'(sprite_count * sprite_pixels);
        sprite_write.address = writedata[21:8];
        sprite_write.index = writedata[7:0];
    end

endmodule

/* design/object_search.sv */
// Pipeline stage 1. Finds the highest-numbered active object whose
// 16x16 box covers the current pixel and registers the hit together with
// the sprite pixel address, sprite * 256 + row * 16 + column.

`timescale 1ns/10ps

module object_search import video_timing_pkg::*, sprite_pkg::*; #(
    parameter int num_objects  = 8,
    parameter int sprite_count = 4
) (
    input  logic                      clk,
    input  logic                      reset,
    input  raster_t                   raster_in,
    input  object_t [num_objects-1:0] objects,
    output raster_t                   raster_out,
    output logic                      hit,
    output logic [13:0]               pixel_address
);

    logic [12:0] column;
    logic [12:0] line;
    logic [12:0] dx;
    logic [12:0] dy;
    logic        found;
    logic [5:0]  sprite_raw;
    logic [3:0]  off_x;
    logic [3:0]  off_y;

    always_comb begin
        column = 13'(raster_in.hcount[10:1]);  // two counts per pixel
        line = 13'(raster_in.vcount);
        dx = '0;
        dy = '0;
        found = 1'b0;
        sprite_raw = '0;
        off_x = '0;
        off_y = '0;
        // later objects overwrite earlier ones, so the highest index wins
        for (int i = 0; i < num_objects; i++) begin
            dx = column - {1'b0, objects[i].x};  // wraps large when left of x
            dy = line - {1'b0, objects[i].y};
            if (objects[i].active && dx < 13'(sprite_dim) && dy < 13'(sprite_dim)) begin
                found = 1'b1;
                sprite_raw = objects[i].sprite;
                off_x = dx[3:0];
                off_y = dy[3:0];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster_out <= raster_idle;
            hit <= 1'b0;
            pixel_address <= '0;
        end else begin
            raster_out <= raster_in;
            hit <= found;
            pixel_address <= {6'(sprite_raw % sprite_count), off_y, off_x};
        end
    end

endmodule

/* design/sprite_memory.sv */
// Pipeline stage 2. Sprite pixel RAM holding sprite_count sprites of
// 256 colour indices, written from the bus and read once per clock.
// The raster and hit travel alongside the registered read.

`timescale 1ns/10ps

module sprite_memory import video_timing_pkg::*, sprite_pkg::*; #(
    parameter int sprite_count = 4
) (
    input  logic          clk,
    input  logic          reset,
    input  sprite_write_t sprite_write,
    input  raster_t       raster_in,
    input  logic          hit_in,
    input  logic [13:0]   pixel_address,
    output raster_t       raster_out,
    output logic          hit_out,
    output pixel_index_t  index
);

    localparam int depth = sprite_count * sprite_pixels;
    localparam int addr_bits = $clog2(depth);

    pixel_index_t mem [depth] = '{default: '0};  // starts transparent

    always_ff @(posedge clk) begin
        if (sprite_write.strobe) begin
            mem[sprite_write.address[addr_bits-1:0]] <= sprite_write.index;
        end
        index <= mem[pixel_address[addr_bits-1:0]];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster_out <= raster_idle;
            hit_out <= 1'b0;
        end else begin
            raster_out <= raster_in;
            hit_out <= hit_in;
        end
    end

endmodule

/* design/pixel_compose.sv */
// Pipeline stages 3 and 4. Stage 3 turns the colour index into RGB from
// the 6x6x6 colour cube, stage 4 composes against the background and
// drives the VGA pins. Black sprite colours are transparent.

`timescale 1ns/10ps

module pixel_compose import video_timing_pkg::*, sprite_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  raster_t      raster_in,
    input  logic         hit_in,
    input  pixel_index_t index,
    input  rgb_t         background,
    output logic [7:0]   vga_r,
    output logic [7:0]   vga_g,
    output logic [7:0]   vga_b,
    output logic         vga_hs,
    output logic         vga_vs,
    output logic         vga_blank_n,
    output logic         vga_clk
);

    rgb_t    palette;
    rgb_t    colour;
    raster_t raster_s3;
    logic    hit_s3;

    always_comb begin
        palette = '0;  // 216 and up stay black
        if (index < 8'd216) begin
            palette.r = (index / 8'd36) * 8'h33;
            palette.g = ((index / 8'd6) % 8'd6) * 8'h33;
            palette.b = (index % 8'd6) * 8'h33;
        end
    end

    always_ff @(posedge clk) begin
        colour <= palette;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            raster_s3 <= raster_idle;
            hit_s3 <= 1'b0;
            {vga_r, vga_g, vga_b} <= '0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
            vga_blank_n <= 1'b0;
            vga_clk <= 1'b0;
        end else begin
            raster_s3 <= raster_in;
            hit_s3 <= hit_in;
            if (!raster_s3.blank_n) begin
                {vga_r, vga_g, vga_b} <= '0;
            end else if (!hit_s3 || colour == '0) begin
                {vga_r, vga_g, vga_b} <= background;
            end else begin
                {vga_r, vga_g, vga_b} <= colour;
            end
            vga_hs <= raster_s3.hsync;
            vga_vs <= raster_s3.vsync;
            vga_blank_n <= raster_s3.blank_n;
            vga_clk <= raster_s3.pix_clk;
        end
    end

endmodule

/* design/vga_sprite_engine.sv */
// VGA sprite engine top. Software writes the background, object table and
// sprite pixels over a simple strobe bus; the raster timer feeds a
// four-stage pipeline whose colour and sync leave four clocks later.
// num_objects must stay at 30 or below to fit the bus address map.

`timescale 1ns/10ps

module vga_sprite_engine import video_timing_pkg::*, sprite_pkg::*; #(
    parameter int num_objects  = 8,
    parameter int sprite_count = 4,
    parameter int h_active     = 1280,
    parameter int h_front      = 32,
    parameter int h_sync       = 192,
    parameter int h_back       = 96,
    parameter int v_active     = 480,
    parameter int v_front      = 10,
    parameter int v_sync       = 2,
    parameter int v_back       = 33
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        chipselect,
    input  logic        write,
    input  logic [4:0]  address,
    input  logic [31:0] writedata,
    output logic [7:0]  VGA_R,
    output logic [7:0]  VGA_G,
    output logic [7:0]  VGA_B,
    output logic        VGA_CLK,
    output logic        VGA_HS,
    output logic        VGA_VS,
    output logic        VGA_BLANK_n,
    output logic        VGA_SYNC_n
);

    raster_t                   timer_raster;
    raster_t                   search_raster;
    raster_t                   memory_raster;
    rgb_t                      background;
    object_t [num_objects-1:0] objects;
    sprite_write_t             sprite_write;
    logic                      search_hit;
    logic                      memory_hit;
    logic [13:0]               pixel_address;
    pixel_index_t              index;

    assign VGA_SYNC_n = 1'b0;  // no sync on green

    raster_timing #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_raster_timing (.clk, .reset, .raster(timer_raster));

    register_bank #(.num_objects(num_objects), .sprite_count(sprite_count)) i_register_bank (
        .clk, .reset, .chipselect, .write, .address, .writedata,
        .background, .objects, .sprite_write
    );

    object_search #(.num_objects(num_objects), .sprite_count(sprite_count)) i_object_search (
        .clk, .reset, .raster_in(timer_raster), .objects,
        .raster_out(search_raster), .hit(search_hit), .pixel_address
    );

    sprite_memory #(.sprite_count(sprite_count)) i_sprite_memory (
        .clk, .reset, .sprite_write, .raster_in(search_raster), .hit_in(search_hit),
        .pixel_address, .raster_out(memory_raster), .hit_out(memory_hit), .index
    );

    pixel_compose i_pixel_compose (
        .clk, .reset, .raster_in(memory_raster), .hit_in(memory_hit), .index, .background,
        .vga_r(VGA_R), .vga_g(VGA_G), .vga_b(VGA_B), .vga_hs(VGA_HS), .vga_vs(VGA_VS),
        .vga_blank_n(VGA_BLANK_n), .vga_clk(VGA_CLK)
    );

endmodule

/* test/pixel_checker.sv */
// Pixel checker for the sprite engine testbench. Rebuilds column and line
// from the HS and VS falling edges of the DUT outputs alone, compares the
// probes of the armed test in the next full field and checks sync periods
// and the pixel clock. The testbench arms it with a one-cycle start pulse.

`timescale 1ns/10ps

module pixel_checker #(
    parameter int h_active = 128,
    parameter int h_front  = 8,
    parameter int h_sync   = 16,
    parameter int h_back   = 8,
    parameter int v_active = 48,
    parameter int v_front  = 2,
    parameter int v_sync   = 2,
    parameter int v_back   = 4
) (
    input  logic              clk,
    input  logic              reset,
    input  logic [7:0]        vga_r,
    input  logic [7:0]        vga_g,
    input  logic [7:0]        vga_b,
    input  logic              vga_hs,
    input  logic              vga_vs,
    input  logic              vga_blank_n,
    input  logic              vga_clk,
    input  logic              start,
    input  logic [255:0]      test_name,
    input  logic [4:0]        probe_count,
    input  logic [15:0][39:0] probes,      // column, line, rgb
    output int                tests_done,
    output int                check_count,
    output int                error_count
);

    localparam int h_total = h_active + h_front + h_sync + h_back;
    localparam int v_total = v_active + v_front + v_sync + v_back;
    localparam int field_cycles = h_total * v_total;
    // cycles after the HS fall sample where hcount 0 shows up
    localparam int active_offset = h_sync + h_back - 1;
    // raster hcount of the sample where cyc is 0
    localparam int first_count = h_active + h_front + 1;

    int          cyc;
    int          vcyc;
    int          cur_line;
    int          next_line;
    int          test_errors;
    logic        hs_q;
    logic        vs_q;
    logic        hcyc_valid;
    logic        vcyc_valid;
    logic        line_valid;
    logic        armed;
    logic        checking;
    logic [15:0] seen;

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cyc <= 0;
            vcyc <= 0;
            cur_line <= 0;
            next_line <= 0;
            hs_q <= 1'b1;
            vs_q <= 1'b1;
            hcyc_valid <= 1'b0;
            vcyc_valid <= 1'b0;
            line_valid <= 1'b0;
            armed <= 1'b0;
            checking <= 1'b0;
            seen <= '0;
            tests_done = 0;
            check_count = 0;
            error_count = 0;
            test_errors = 0;
        end else begin
            hs_q <= vga_hs;
            vs_q <= vga_vs;
            cyc <= cyc + 1;
            vcyc <= vcyc + 1;
            if (start) begin
                armed <= 1'b1;
                seen <= '0;
                test_errors = 0;
            end
            // pixel clock is bit 0 of the raster count
            if (hcyc_valid && (first_count + cyc) % 2 != int'(vga_clk)) begin
                $display("VGA_CLK is %b at %0d cycles after the HS fall", vga_clk, cyc + 1);
                error_count++;
            end
            if (vs_q && !vga_vs) begin
                if (vcyc_valid && vcyc != field_cycles - 1) begin
                    $display("VS falling edges %0d cycles apart instead of %0d",
                             vcyc + 1, field_cycles);
                    error_count++;
                end
                vcyc <= 0;
                vcyc_valid <= 1'b1;
                next_line <= v_active + v_front + 1;  // HS of the sync line starts this one
                line_valid <= 1'b1;
            end
            if (hs_q && !vga_hs) begin
                if (hcyc_valid && cyc != h_total - 1) begin
                    $display("HS falling edges %0d cycles apart instead of %0d",
                             cyc + 1, h_total);
                    error_count++;
                end
                cyc <= 0;
                hcyc_valid <= 1'b1;
                if (line_valid) begin
                    cur_line <= next_line;
                    next_line <= (next_line + 1) % v_total;
                    if (armed && next_line == 0) begin
                        armed <= 1'b0;
                        checking <= 1'b1;
                    end
                    if (checking && next_line == v_active) begin
                        checking <= 1'b0;
                        for (int i = 0; i < int'(probe_count); i++) begin
                            if (!seen[i]) begin
                                $display("%0s: probe %0d was never reached in the field",
                                         test_name, i);
                                test_errors++;
                                error_count++;
                            end
                        end
                        if (test_errors == 0) begin
                            $display("%0s: ok", test_name);
                        end else begin
                            $display("%0s: %0d errors", test_name, test_errors);
                        end
                        tests_done++;
                    end
                end
            end
            if (checking) begin
                for (int i = 0; i < int'(probe_count); i++) begin
                    if (cur_line == int'(probes[i][31:24]) &&
                        cyc == active_offset + 2 * int'(probes[i][39:32])) begin
                        seen[i] <= 1'b1;
                        check_count++;
                        if (!vga_blank_n) begin
                            $display("%0s: pixel %0d,%0d is blanked", test_name,
                                     probes[i][39:32], probes[i][31:24]);
                            test_errors++;
                            error_count++;
                        end else if ({vga_r, vga_g, vga_b} != probes[i][23:0]) begin
                            $display("MISMATCH %0s pixel %0d,%0d expected %06h actual %06h",
                                     test_name, probes[i][39:32], probes[i][31:24],
                                     probes[i][23:0], {vga_r, vga_g, vga_b});
                            test_errors++;
                            error_count++;
                        end
                    end
                end
            end
        end
    end

endmodule

/* test/vga_sprite_engine_sva.sv */
// Assertions on the VGA outputs of the sprite engine, bound to its top.
// Checks the tied-off sync pin, black during blanking and HS pulse width.

`timescale 1ns/10ps

module vga_sprite_engine_sva #(
    parameter int h_sync = 192
) (
    input logic       clk,
    input logic       reset,
    input logic [7:0] VGA_R,
    input logic [7:0] VGA_G,
    input logic [7:0] VGA_B,
    input logic       VGA_HS,
    input logic       VGA_BLANK_n,
    input logic       VGA_SYNC_n
);

    int hs_low_count;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hs_low_count <= 0;
        end else begin
            hs_low_count <= VGA_HS ? 0 : hs_low_count + 1;
        end
    end

    sync_n_low: assert property (@(posedge clk) disable iff (reset) !VGA_SYNC_n)
        else $error("VGA_SYNC_n is not low");

    black_when_blank: assert property (@(posedge clk) disable iff (reset)
        !VGA_BLANK_n |-> {VGA_R, VGA_G, VGA_B} == 24'h0)
        else $error("colour is not black during blanking");

    hs_pulse_width: assert property (@(posedge clk) disable iff (reset)
        $rose(VGA_HS) |-> hs_low_count == h_sync)
        else $error("HS low pulse lasted %0d cycles", hs_low_count);

endmodule

bind vga_sprite_engine vga_sprite_engine_sva #(.h_sync(h_sync)) i_vga_sprite_engine_sva (
    .clk(clk), .reset(reset), .VGA_R(VGA_R), .VGA_G(VGA_G), .VGA_B(VGA_B),
    .VGA_HS(VGA_HS), .VGA_BLANK_n(VGA_BLANK_n), .VGA_SYNC_n(VGA_SYNC_n)
);

/* test/tb_vga_sprite_engine.sv */
// Testbench for the VGA sprite engine with a small raster. Reads tests from
// the stimulus file, applies each test's bus writes during vertical
// blanking and hands its probes to the pixel checker for the next field.

`timescale 1ns/10ps

module tb_vga_sprite_engine;

    localparam int h_active = 128;
    localparam int h_front = 8;
    localparam int h_sync = 16;
    localparam int h_back = 8;
    localparam int v_active = 48;
    localparam int v_front = 2;
    localparam int v_sync = 2;
    localparam int v_back = 4;
    localparam int field_cycles = (h_active + h_front + h_sync + h_back) *
                                  (v_active + v_front + v_sync + v_back);

    logic              clk = 1'b0;
    logic              reset = 1'b1;
    logic              chipselect = 1'b0;
    logic              write = 1'b0;
    logic [4:0]        address = '0;
    logic [31:0]       writedata = '0;
    logic [7:0]        vga_r, vga_g, vga_b;
    logic              vga_clk, vga_hs, vga_vs, vga_blank_n, vga_sync_n;
    logic              start = 1'b0;
    logic [255:0]      test_name_bits = '0;
    logic [4:0]        probe_count = '0;
    logic [15:0][39:0] probes = '0;
    int                tests_done, check_count, error_count;
    string             lines[$];
    logic [4:0]        wr_addr[$];
    logic [31:0]       wr_data[$];
    int                num_tests = 0;
    int                cycles = 0;
    int                limit = 0;

    always #4 clk = ~clk;

    vga_sprite_engine #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_vga_sprite_engine (
        .clk, .reset, .chipselect, .write, .address, .writedata,
        .VGA_R(vga_r), .VGA_G(vga_g), .VGA_B(vga_b), .VGA_CLK(vga_clk), .VGA_HS(vga_hs),
        .VGA_VS(vga_vs), .VGA_BLANK_n(vga_blank_n), .VGA_SYNC_n(vga_sync_n)
    );

    pixel_checker #(
        .h_active(h_active), .h_front(h_front), .h_sync(h_sync), .h_back(h_back),
        .v_active(v_active), .v_front(v_front), .v_sync(v_sync), .v_back(v_back)
    ) i_pixel_checker (
        .clk, .reset, .vga_r, .vga_g, .vga_b, .vga_hs, .vga_vs, .vga_blank_n, .vga_clk,
        .start, .test_name(test_name_bits), .probe_count, .probes, .tests_done,
        .check_count, .error_count
    );

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout after %0d cycles with %0d of %0d tests done",
                     cycles, tests_done, num_tests);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [255:0] pack_name(string name);
        logic [255:0] bits = '0;
        for (int k = 0; k < name.len() && k < 32; k++) begin
            bits = {bits[247:0], name[k]};
        end
        return bits;
    endfunction

    task automatic bus_write(logic [4:0] a, logic [31:0] d);
        chipselect = 1'b1;
        write = 1'b1;
        address = a;
        writedata = d;
        @(negedge clk);
        chipselect = 1'b0;
        write = 1'b0;
    endtask

    // writes go in right after the VS fall, well inside vertical blanking
    task automatic apply_test(string name);
        int target;
        target = tests_done + 1;
        @(negedge vga_vs);
        @(negedge clk);
        foreach (wr_addr[i]) bus_write(wr_addr[i], wr_data[i]);
        test_name_bits = pack_name(name);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        while (tests_done < target) @(negedge clk);
    endtask

    initial begin
        int          fd;
        int          col, ln;
        string       l, kw, name;
        logic [31:0] a, d, rgb;
        fd = $fopen("test/vga_sprite_stimulus.txt", "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file");
            $display("test failed");
            $finish;
        end else begin
            while (!$feof(fd)) begin
                if ($fgets(l, fd) != 0) lines.push_back(l);
            end
            $fclose(fd);
            foreach (lines[i]) begin
                if ($sscanf(lines[i], "%s", kw) == 1 && kw == "test") num_tests++;
            end
            limit = num_tests * 2 * field_cycles + 2000;
            repeat (2) @(negedge clk);
            reset = 1'b0;
            foreach (lines[i]) begin
                if ($sscanf(lines[i], "%s", kw) != 1 || kw.substr(0, 0) == "#") continue;
                if (kw == "test") begin
                    void'($sscanf(lines[i], "%s %s", kw, name));
                    wr_addr.delete();
                    wr_data.delete();
                    probe_count = '0;
                end else if (kw == "write") begin
                    void'($sscanf(lines[i], "%s %h %h", kw, a, d));
                    wr_addr.push_back(a[4:0]);
                    wr_data.push_back(d);
                end else if (kw == "probe") begin
                    void'($sscanf(lines[i], "%s %d %d %h", kw, col, ln, rgb));
                    probes[probe_count] = {8'(col), 8'(ln), rgb[23:0]};
                    probe_count = probe_count + 5'd1;
                end else if (kw == "end") begin
                    apply_test(name);
                end
            end
            $display("%0d tests, %0d checks, %0d errors", tests_done, check_count, error_count);
            if (error_count == 0 && tests_done == num_tests && check_count > 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

/* test/vga_sprite_stimulus.txt */
# test <name> | write <address hex> <data hex> | probe <column> <line> <rgb hex> | end
test reset_background
probe 0 0 000080
probe 63 47 000080
probe 20 10 000080
end
test background_write
write 00 00204060
probe 0 0 204060
probe 40 30 204060
end
test sprite_palette
write 1f 00010005
write 1f 000101d7
write 1f 000102e6
write 1f 00011024
write 01 00a00506
probe 10 5 0000ff
probe 11 5 ffffff
probe 12 5 204060
probe 10 6 330000
probe 13 5 204060
probe 9 5 204060
end
test overlap_priority
write 1f 00020101
write 02 00a0050a
probe 10 5 204060
probe 11 5 000033
probe 10 6 204060
end
test remove_and_ignore
write 02 00a00508
write 09 01e01406
probe 10 5 0000ff
probe 11 5 ffffff
probe 30 20 204060
end

/* verilog.f */
design/video_timing_pkg.sv
design/sprite_pkg.sv
design/raster_timing.sv
design/register_bank.sv
design/object_search.sv
design/sprite_memory.sv
design/pixel_compose.sv
design/vga_sprite_engine.sv
test/pixel_checker.sv
test/vga_sprite_engine_sva.sv
test/tb_vga_sprite_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_vga_sprite_engine
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(BUILD_DIR)
